//--- verilog/tilemap_cfg.svh
`ifndef TM_CFG_SVH
`define TM_CFG_SVH
`default_nettype none

// bit-planes per layer, one bit of the pixel code each
`define TM_PLANES 3
// pixels carried by one plane nibble of a graphics word
`define TM_PIX_PER_FETCH 4

// pixel code treated as see-through by the mixer
`define TM_TRANSPARENT 3'd7

// cpu register map with data taken from mdi[3:1]
`define TM_ADDR_PRI_A 3'd1
`define TM_ADDR_PRI_B 3'd5

`default_nettype wire
`endif

//--- verilog/tilemap_pkg.sv
`default_nettype none

package tilemap_pkg;

	// one bit per plane with plane 2 in the msb
	typedef logic [2:0] pix_code_t;

	// tile attribute byte that also serves as palette bank on the output
	typedef logic [7:0] color_t;

	// layer priority as written by the cpu
	typedef logic [2:0] prio_t;

	// three plane nibbles of four pixels
	// plane 0 in [3:0], plane 1 in [7:4], plane 2 in [11:8]
	typedef logic [11:0] gfx_word_t;

	// cpu register select
	typedef logic [2:0] reg_addr_t;

endpackage

`default_nettype wire

//--- verilog/tile_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module tile_fetch (
	input  wire                       CLK_6M,
	input  wire                       layer,
	input  wire                       phase,
	input  wire tilemap_pkg::color_t    mdi,
	input  wire tilemap_pkg::gfx_word_t gdi,
	output tilemap_pkg::color_t       attr_a,
	output tilemap_pkg::gfx_word_t    gfx_a,
	output tilemap_pkg::color_t       attr_b,
	output tilemap_pkg::gfx_word_t    gfx_b
);

	// registered copy of the half-line phase
	logic phase_q;
	// high on the edge where the phase has just flipped
	logic phase_chg;

	assign phase_chg = (phase != phase_q);

	//////////////////////////////////////////////////
	// phase tracking
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge layer) begin
		if (!layer) begin
			phase_q <= 1'b0;
		end else begin
			phase_q <= phase;
		end
	end

	//////////////////////////////////////////////////
	// layer slots
	//////////////////////////////////////////////////

	// the shared buses belong to the half that just ended
	// rising phase closes the a half, falling phase the b half
	always_ff @(posedge CLK_6M or negedge layer) begin
		if (!layer) begin
			attr_a <= '0;
			gfx_a  <= '0;
			attr_b <= '0;
			gfx_b  <= '0;
		end else if (phase_chg) begin
			if (phase) begin
				attr_a <= mdi;
				gfx_a  <= gdi;
			end else begin
				attr_b <= mdi;
				gfx_b  <= gdi;
			end
		end
		// slots hold until the next capture of their own half
	end

	// each half lasts two cycles or more
	// so a flip is never followed by another flip on the next edge
	a_phase_hold : assert property (
		@(posedge CLK_6M) disable iff (!layer)
		phase_chg |=> !phase_chg
	) else $error("phase changed on two consecutive edges");

endmodule

`default_nettype wire

//--- verilog/plane_shifter.sv
`timescale 1ns/10ps
`include "tilemap_cfg.svh"
`default_nettype none

module plane_shifter (
	input  wire                         CLK_6M,
	input  wire                         layer,
	input  wire                         load,
	input  wire tilemap_pkg::color_t    attr,
	input  wire tilemap_pkg::gfx_word_t gfx,
	output tilemap_pkg::color_t         color,
	output tilemap_pkg::pix_code_t      pix
);

	// one nibble per plane in the same order as the graphics word
	logic [`TM_PLANES-1:0][`TM_PIX_PER_FETCH-1:0] planes;

	//////////////////////////////////////////////////
	// load and shift
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge layer) begin
		if (!layer) begin
			color  <= '0;
			planes <= '0;
		end else if (load) begin
			// new tile group whose attribute stays for all four pixels
			color  <= attr;
			planes <= gfx;
		end else begin
			// msb first with zeros filling in behind
			for (int i = 0; i < `TM_PLANES; i++) begin
				planes[i] <= {planes[i][`TM_PIX_PER_FETCH-2:0], 1'b0};
			end
		end
	end

	//////////////////////////////////////////////////
	// pixel code
	//////////////////////////////////////////////////

	// top bit of every plane forms the current code
	always_comb begin
		for (int i = 0; i < `TM_PLANES; i++) begin
			pix[i] = planes[i][`TM_PIX_PER_FETCH-1];
		end
	end

	// graphics bus must be clean once loads start after reset
	a_pix_known : assert property (
		@(posedge CLK_6M) disable iff (!layer)
		!$isunknown(pix)
	) else $error("pixel code unknown");

endmodule

`default_nettype wire

//--- verilog/layer_mixer.sv
`timescale 1ns/10ps
`include "tilemap_cfg.svh"
`default_nettype none

module layer_mixer (
	input  wire                         CLK_6M,
	input  wire                         layer,
	input  wire                         cpu_wr,
	input  wire tilemap_pkg::reg_addr_t ca,
	input  wire tilemap_pkg::color_t    mdi,
	input  wire tilemap_pkg::pix_code_t pix_a,
	input  wire tilemap_pkg::color_t    color_a,
	input  wire tilemap_pkg::pix_code_t pix_b,
	input  wire tilemap_pkg::color_t    color_b,
	input  wire tilemap_pkg::prio_t     pri_in,
	input  wire tilemap_pkg::color_t    cl_in,
	input  wire tilemap_pkg::pix_code_t dt_in,
	output tilemap_pkg::prio_t          pri_out,
	output tilemap_pkg::color_t         cl_out,
	output tilemap_pkg::pix_code_t      dt_out
);

	import tilemap_pkg::*;

	// per-layer priorities from the cpu
	prio_t pri_a;
	prio_t pri_b;

	// transparency flags for both layers
	logic a_clear;
	logic b_clear;
	// b takes the layer stage
	logic b_wins;

	// winner of the a/b stage
	prio_t     pri_m;
	color_t    col_m;
	pix_code_t pix_m;

	//////////////////////////////////////////////////
	// cpu priority registers
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge layer) begin
		if (!layer) begin
			pri_a <= '0;
			pri_b <= '0;
		end else if (cpu_wr) begin
			// other addresses belong to the scroll side and are ignored here
			if (ca == `TM_ADDR_PRI_A) begin
				pri_a <= mdi[3:1];
			end else if (ca == `TM_ADDR_PRI_B) begin
				pri_b <= mdi[3:1];
			end
		end
	end

	//////////////////////////////////////////////////
	// arbitration
	//////////////////////////////////////////////////

	always_comb begin
		a_clear = (pix_a == `TM_TRANSPARENT);
		b_clear = (pix_b == `TM_TRANSPARENT);
		// ties go to a
		b_wins  = !b_clear && (a_clear || (pri_b > pri_a));
		pri_m   = b_wins ? pri_b : pri_a;
		col_m   = b_wins ? color_b : color_a;
		pix_m   = b_wins ? pix_b : pix_a;
		// chained pixel keeps the spot unless strictly beaten
		if ((pix_m != `TM_TRANSPARENT) && (pri_m > pri_in)) begin
			pri_out = pri_m;
			cl_out  = col_m;
			dt_out  = pix_m;
		end else begin
			pri_out = pri_in;
			cl_out  = cl_in;
			dt_out  = dt_in;
		end
	end

	// the cpu decode must see a defined address on every write
	a_wr_addr_known : assert property (
		@(posedge CLK_6M) disable iff (!layer)
		cpu_wr |-> !$isunknown(ca)
	) else $error("cpu write with unknown address");

endmodule

`default_nettype wire

//--- verilog/tilemap_top.sv
`timescale 1ns/10ps
`default_nettype none

module tilemap_top (
	input  wire                         CLK_6M,
	input  wire                         layer,
	input  wire                         phase,
	input  wire tilemap_pkg::color_t    mdi,
	input  wire tilemap_pkg::gfx_word_t gdi,
	input  wire                         load_a,
	input  wire                         load_b,
	input  wire                         cpu_wr,
	input  wire tilemap_pkg::reg_addr_t ca,
	input  wire tilemap_pkg::prio_t     pri_in,
	input  wire tilemap_pkg::color_t    cl_in,
	input  wire tilemap_pkg::pix_code_t dt_in,
	output tilemap_pkg::prio_t          pri_out,
	output tilemap_pkg::color_t         cl_out,
	output tilemap_pkg::pix_code_t      dt_out
);

	import tilemap_pkg::*;

	// fetch slots
	color_t    attr_a;
	gfx_word_t gfx_a;
	color_t    attr_b;
	gfx_word_t gfx_b;

	// shifter outputs into the mixer
	color_t    color_a;
	pix_code_t pix_a;
	color_t    color_b;
	pix_code_t pix_b;

	//////////////////////////////////////////////////
	// producer, two buffers, consumer
	//////////////////////////////////////////////////

	tile_fetch fetch (
		.CLK_6M (CLK_6M), .layer (layer), .phase (phase),
		.mdi (mdi), .gdi (gdi),
		.attr_a (attr_a), .gfx_a (gfx_a), .attr_b (attr_b), .gfx_b (gfx_b)
	);

	plane_shifter shift_a (
		.CLK_6M (CLK_6M), .layer (layer), .load (load_a),
		.attr (attr_a), .gfx (gfx_a), .color (color_a), .pix (pix_a)
	);

	plane_shifter shift_b (
		.CLK_6M (CLK_6M), .layer (layer), .load (load_b),
		.attr (attr_b), .gfx (gfx_b), .color (color_b), .pix (pix_b)
	);

	// mdi doubles as the cpu data bus for priority writes
	layer_mixer mixer (
		.CLK_6M (CLK_6M), .layer (layer), .cpu_wr (cpu_wr), .ca (ca), .mdi (mdi),
		.pix_a (pix_a), .color_a (color_a), .pix_b (pix_b), .color_b (color_b),
		.pri_in (pri_in), .cl_in (cl_in), .dt_in (dt_in),
		.pri_out (pri_out), .cl_out (cl_out), .dt_out (dt_out)
	);

endmodule

`default_nettype wire

//--- verification/tb_tilemap.sv
`timescale 1ns/10ps
`include "tilemap_cfg.svh"
`default_nettype none

module tb_tilemap;

	import tilemap_pkg::*;

	localparam int RUN_CYCLES = 3000;
	localparam int RESET_WAIT = 10;

	// dut ports
	logic      CLK_6M;
	logic      layer;
	logic      phase;
	color_t    mdi;
	gfx_word_t gdi;
	logic      load_a;
	logic      load_b;
	logic      cpu_wr;
	reg_addr_t ca;
	prio_t     pri_in;
	color_t    cl_in;
	pix_code_t dt_in;
	prio_t     pri_out;
	color_t    cl_out;
	pix_code_t dt_out;

	// stimulus state
	logic [31:0] seed;
	int          hold_left;
	int          cycle;
	int          n;
	time         t_start;
	time         run_limit;

	// reference model state with the hardware reset values
	logic      m_phase_q;
	color_t    m_attr_a;
	color_t    m_attr_b;
	gfx_word_t m_gfx_a;
	gfx_word_t m_gfx_b;
	color_t    m_col_a;
	color_t    m_col_b;
	gfx_word_t m_pl_a;
	gfx_word_t m_pl_b;
	prio_t     m_pri_a;
	prio_t     m_pri_b;

	// predicted outputs for the current cycle
	prio_t     exp_pri;
	color_t    exp_cl;
	pix_code_t exp_dt;

	tilemap_top dut (
		.CLK_6M (CLK_6M), .layer (layer), .phase (phase), .mdi (mdi), .gdi (gdi),
		.load_a (load_a), .load_b (load_b), .cpu_wr (cpu_wr), .ca (ca),
		.pri_in (pri_in), .cl_in (cl_in), .dt_in (dt_in),
		.pri_out (pri_out), .cl_out (cl_out), .dt_out (dt_out)
	);

	// 20 ns period
	always #10 CLK_6M = ~CLK_6M;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// lcg step whose upper bits are the useful ones
	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_prio(input prio_t got, input prio_t exp, input string what);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_color(input color_t got, input color_t exp, input string what);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %02h, expected %02h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_pix(input pix_code_t got, input pix_code_t exp, input string what);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// msb of each plane nibble with plane 0 in bit 0
	function automatic pix_code_t plane_code(input gfx_word_t g);
		pix_code_t c;
		for (int p = 0; p < `TM_PLANES; p++) begin
			c[p] = g[p*`TM_PIX_PER_FETCH + `TM_PIX_PER_FETCH-1];
		end
		return c;
	endfunction

	// every nibble moves one place up and takes a zero at the bottom
	function automatic gfx_word_t shift_planes(input gfx_word_t g);
		gfx_word_t s;
		s = g;
		for (int p = 0; p < `TM_PLANES; p++) begin
			s[p*`TM_PIX_PER_FETCH +: `TM_PIX_PER_FETCH] =
				g[p*`TM_PIX_PER_FETCH +: `TM_PIX_PER_FETCH] << 1;
		end
		return s;
	endfunction

	// output rules from the current model state and live inputs
	task automatic predict_outputs();
		pix_code_t pa;
		pix_code_t pb;
		logic      take_b;
		pa = plane_code(m_pl_a);
		pb = plane_code(m_pl_b);
		// b needs a visible pixel and either a clear a or a strictly higher priority
		take_b = (pb != `TM_TRANSPARENT) && ((pa == `TM_TRANSPARENT) || (m_pri_b > m_pri_a));
		exp_pri = take_b ? m_pri_b : m_pri_a;
		exp_cl  = take_b ? m_col_b : m_col_a;
		exp_dt  = take_b ? pb : pa;
		// chained pixel stays unless beaten by a visible layer pixel
		if (!((exp_dt != `TM_TRANSPARENT) && (exp_pri > pri_in))) begin
			exp_pri = pri_in;
			exp_cl  = cl_in;
			exp_dt  = dt_in;
		end
	endtask

	// one rising edge where the shifters see the slots from before the capture
	task automatic advance_model();
		m_pl_a  = load_a ? m_gfx_a : shift_planes(m_pl_a);
		m_col_a = load_a ? m_attr_a : m_col_a;
		m_pl_b  = load_b ? m_gfx_b : shift_planes(m_pl_b);
		m_col_b = load_b ? m_attr_b : m_col_b;
		if (cpu_wr && (ca == `TM_ADDR_PRI_A)) begin
			m_pri_a = mdi[3:1];
		end else if (cpu_wr && (ca == `TM_ADDR_PRI_B)) begin
			m_pri_b = mdi[3:1];
		end
		// rising phase fills slot a, falling phase slot b
		if (phase != m_phase_q) begin
			if (phase) begin
				m_attr_a = mdi;
				m_gfx_a  = gdi;
			end else begin
				m_attr_b = mdi;
				m_gfx_b  = gdi;
			end
		end
		m_phase_q = phase;
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic drive_inputs();
		logic [31:0] r;
		r = lcg_next();
		mdi = r[31:24];
		r = lcg_next();
		gdi = r[31:20];
		r = lcg_next();
		// pri_in held at 0 now and then so the layers get through
		pri_in = (r[31:30] == 2'b00) ? 3'd0 : r[29:27];
		cl_in  = r[26:19];
		dt_in  = r[18:16];
		r = lcg_next();
		cpu_wr = (r[31:30] == 2'b00);
		ca     = r[29:27];
		load_a = (r[23:16] < 8'd85);
		r = lcg_next();
		load_b = (r[31:24] < 8'd85);
		// each phase half lasts two to five cycles
		if (hold_left <= 1) begin
			phase     = ~phase;
			hold_left = 2 + int'(r[23:22]);
		end else begin
			hold_left--;
		end
	endtask

	initial begin
		layer = 1'b0;
		repeat (2) @(posedge CLK_6M);
		#2 layer = 1'b1;
	end

	initial begin
		CLK_6M = 1'b0;
		phase  = 1'b0;
		mdi    = '0;
		gdi    = '0;
		load_a = 1'b0;
		load_b = 1'b0;
		cpu_wr = 1'b0;
		ca     = '0;
		pri_in = '0;
		cl_in  = '0;
		dt_in  = '0;
		seed      = 32'hecf1_ec18;
		hold_left = 3;
		m_phase_q = 1'b0;
		m_attr_a  = '0;
		m_attr_b  = '0;
		m_gfx_a   = '0;
		m_gfx_b   = '0;
		m_col_a   = '0;
		m_col_b   = '0;
		m_pl_a    = '0;
		m_pl_b    = '0;
		m_pri_a   = '0;
		m_pri_b   = '0;

		// bounded wait for reset release
		n = 0;
		while ((layer !== 1'b1) && (n < RESET_WAIT)) begin
			@(posedge CLK_6M);
			n++;
		end
		if (layer !== 1'b1) begin
			$display("timeout: reset was never released");
			abort_run();
		end

		// main run with outputs checked 1 ns before each edge
		t_start   = $time;
		run_limit = 64'd20 * (RUN_CYCLES + 10);
		cycle     = 0;
		while (cycle < RUN_CYCLES) begin
			#2;
			drive_inputs();
			#17;
			predict_outputs();
			check_prio(pri_out, exp_pri, "pri_out");
			check_color(cl_out, exp_cl, "cl_out");
			check_pix(dt_out, exp_dt, "dt_out");
			advance_model();
			@(posedge CLK_6M);
			cycle++;
			if ($time - t_start > run_limit) begin
				$display("timeout: main run did not finish in time");
				abort_run();
			end
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/tilemap_pkg.sv
verilog/tile_fetch.sv
verilog/plane_shifter.sv
verilog/layer_mixer.sv
verilog/tilemap_top.sv
verification/tb_tilemap.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the tilemap testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f files.f --top-module tb_tilemap \
	-o sim_tilemap > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tilemap > sim.log 2>&1
cat sim.log

grep -qx "RESULT: PASS" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
